/* common/fscb_settings.svh */
// sizing macros shared by the floating-point register scoreboard

`ifndef FSCB_SETTINGS_SVH
`define FSCB_SETTINGS_SVH

// architectural fp registers
`define FSCB_NUM_REGS 32

// width of a register index
`define FSCB_REG_W 5

// issue slots, i0 older and i1 younger
`define FSCB_SLOTS 2

`endif

/* common/fscb_pkg.sv */
// shared types of the fp scoreboard for unit flags and in-flight entries

`default_nettype none

`include "fscb_settings.svh"

package fscb_pkg;

    // functional unit of one instruction
    typedef struct packed {
        logic alu;
        logic load;
        logic fmac;
        logic fdiv;
    } fu_flags_t;

    // one in-flight instruction as seen by the scoreboard
    typedef struct packed {
        logic                   valid;
        logic [`FSCB_REG_W-1:0] rd;
        fu_flags_t              fu;
    } sb_entry_t;

endpackage

`default_nettype wire

/* stage_track/fscb_stage_track.sv */
// stage tracker holding the mm and wb destination entries of both issue slots

`timescale 1ns/1ps
`default_nettype none

`include "fscb_settings.svh"

module fscb_stage_track (
    input  logic                                  core_clk,
    input  logic                                  core_reset_n,
    input  fscb_pkg::sb_entry_t [`FSCB_SLOTS-1:0] ex_entry,
    input  logic                                  lx_stall,
    input  logic                                  wb_kill,
    input  logic                                  mm_i0_kill,
    input  logic                                  mm_i1_kill,
    input  logic                                  wb_i0_doable,
    input  logic                                  wb_i1_doable,
    output fscb_pkg::sb_entry_t [`FSCB_SLOTS-1:0] mm_entry,
    output fscb_pkg::sb_entry_t [`FSCB_SLOTS-1:0] wb_entry,
    output logic                                  fdiv_kill
);

    import fscb_pkg::*;

    logic                   ex_kill;
    logic [`FSCB_SLOTS-1:0] mm_kill;
    logic [`FSCB_SLOTS-1:0] wb_doable;

    // any kill empties the ex pair on its way into mm
    assign ex_kill = wb_kill | mm_i0_kill | mm_i1_kill;

    // the younger mm slot also dies with a kill of the older one
    assign mm_kill[0] = wb_kill;
    assign mm_kill[1] = wb_kill | mm_i0_kill;

    assign wb_doable = {wb_i1_doable, wb_i0_doable};

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            mm_entry <= '0;
            wb_entry <= '0;
        end else if (!lx_stall) begin
            for (int s = 0; s < `FSCB_SLOTS; s++) begin
                if (ex_kill) begin
                    mm_entry[s] <= '0;
                end else begin
                    mm_entry[s] <= ex_entry[s];
                end
                if (mm_kill[s]) begin
                    wb_entry[s] <= '0;
                end else begin
                    wb_entry[s] <= mm_entry[s];
                end
            end
        end
    end

    // the divider drops a request that was killed or not committed in wb
    always_comb begin
        fdiv_kill = 1'b0;
        for (int s = 0; s < `FSCB_SLOTS; s++) begin
            if (ex_entry[s].fu.fdiv && ex_kill) begin
                fdiv_kill = 1'b1;
            end
            if (mm_entry[s].fu.fdiv && mm_kill[s]) begin
                fdiv_kill = 1'b1;
            end
            if (wb_entry[s].fu.fdiv && !wb_doable[s]) begin
                fdiv_kill = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* fdiv_pending/fscb_fdiv_pending.sv */
// map of fp registers whose result is still owed by the divider

`timescale 1ns/1ps
`default_nettype none

`include "fscb_settings.svh"

module fscb_fdiv_pending (
    input  logic                                  core_clk,
    input  logic                                  core_reset_n,
    input  fscb_pkg::sb_entry_t [`FSCB_SLOTS-1:0] wb_entry,
    input  logic                                  wb_i0_doable,
    input  logic                                  wb_i1_doable,
    input  logic                                  fdiv_resp_return,
    input  logic [`FSCB_REG_W-1:0]                fdiv_resp_tag,
    output logic [`FSCB_NUM_REGS-1:0]             pending
);

    import fscb_pkg::*;

    logic [`FSCB_SLOTS-1:0]    wb_doable;
    logic [`FSCB_NUM_REGS-1:0] set_mask;
    logic [`FSCB_NUM_REGS-1:0] clr_mask;

    assign wb_doable = {wb_i1_doable, wb_i0_doable};

    always_comb begin
        set_mask = '0;
        for (int s = 0; s < `FSCB_SLOTS; s++) begin
            if (wb_entry[s].fu.fdiv && wb_doable[s]) begin
                set_mask[wb_entry[s].rd] = 1'b1;
            end
        end
        clr_mask = '0;
        if (fdiv_resp_return) begin
            clr_mask[fdiv_resp_tag] = 1'b1;
        end
    end

    // a response in the same cycle beats a new set
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            pending <= '0;
        end else begin
            pending <= (pending | set_mask) & ~clr_mask;
        end
    end

endmodule

`default_nettype wire

/* hazard/fscb_raw_check.sv */
// read-after-write check of all six fp source operands of the issue pair

`timescale 1ns/1ps
`default_nettype none

`include "fscb_settings.svh"

module fscb_raw_check (
    input  logic [`FSCB_REG_W-1:0]                i0_rs1,
    input  logic [`FSCB_REG_W-1:0]                i0_rs2,
    input  logic [`FSCB_REG_W-1:0]                i0_rs3,
    input  logic [2:0]                            i0_rs_ren,
    input  logic [`FSCB_REG_W-1:0]                i1_rs1,
    input  logic [`FSCB_REG_W-1:0]                i1_rs2,
    input  logic [`FSCB_REG_W-1:0]                i1_rs3,
    input  logic [2:0]                            i1_rs_ren,
    input  logic [`FSCB_REG_W-1:0]                i0_rd,
    input  logic                                  i0_rd_wen,
    input  fscb_pkg::sb_entry_t [`FSCB_SLOTS-1:0] ex_entry,
    input  fscb_pkg::sb_entry_t [`FSCB_SLOTS-1:0] mm_entry,
    input  fscb_pkg::sb_entry_t [`FSCB_SLOTS-1:0] wb_entry,
    input  logic [`FSCB_NUM_REGS-1:0]             pending,
    input  logic                                  fdiv_resp_return,
    input  logic [`FSCB_REG_W-1:0]                fdiv_resp_tag,
    output logic                                  i0_raw_hazard,
    output logic                                  i1_raw_hazard
);

    import fscb_pkg::*;

    logic [`FSCB_NUM_REGS-1:0] stage_busy;
    logic [`FSCB_NUM_REGS-1:0] resp_mask;
    logic [`FSCB_NUM_REGS-1:0] busy;
    logic [`FSCB_NUM_REGS-1:0] i1_busy;
    logic [2:0]                i0_src_busy;
    logic [2:0]                i1_src_busy;

    // registers whose in-flight result cannot be read yet
    // alu results are always ready so they never mark a register
    always_comb begin
        stage_busy = '0;
        for (int s = 0; s < `FSCB_SLOTS; s++) begin
            if (ex_entry[s].valid &&
                (ex_entry[s].fu.load || ex_entry[s].fu.fmac || ex_entry[s].fu.fdiv)) begin
                stage_busy[ex_entry[s].rd] = 1'b1;
            end
            if (mm_entry[s].valid && (mm_entry[s].fu.fmac || mm_entry[s].fu.fdiv)) begin
                stage_busy[mm_entry[s].rd] = 1'b1;
            end
            if (wb_entry[s].valid && wb_entry[s].fu.fdiv) begin
                stage_busy[wb_entry[s].rd] = 1'b1;
            end
        end
    end

    // a returning divide result frees its register this cycle
    always_comb begin
        resp_mask = '0;
        if (fdiv_resp_return) begin
            resp_mask[fdiv_resp_tag] = 1'b1;
        end
    end

    assign busy = stage_busy | (pending & ~resp_mask);

    // i1 also waits on the destination of the older slot
    always_comb begin
        i1_busy = busy;
        if (i0_rd_wen) begin
            i1_busy[i0_rd] = 1'b1;
        end
    end

    assign i0_src_busy = {busy[i0_rs3], busy[i0_rs2], busy[i0_rs1]};
    assign i1_src_busy = {i1_busy[i1_rs3], i1_busy[i1_rs2], i1_busy[i1_rs1]};

    assign i0_raw_hazard = |(i0_rs_ren & i0_src_busy);
    assign i1_raw_hazard = |(i1_rs_ren & i1_src_busy);

endmodule

`default_nettype wire

/* hazard/fscb_issue_check.sv */
// write-after-write and divider or unit structural checks of the issue pair

`timescale 1ns/1ps
`default_nettype none

`include "fscb_settings.svh"

module fscb_issue_check (
    input  logic [`FSCB_REG_W-1:0]                i0_rd,
    input  logic                                  i0_rd_wen,
    input  fscb_pkg::fu_flags_t                   i0_fu,
    input  logic [`FSCB_REG_W-1:0]                i1_rd,
    input  logic                                  i1_rd_wen,
    input  fscb_pkg::fu_flags_t                   i1_fu,
    input  fscb_pkg::sb_entry_t [`FSCB_SLOTS-1:0] ex_entry,
    input  fscb_pkg::sb_entry_t [`FSCB_SLOTS-1:0] mm_entry,
    input  fscb_pkg::sb_entry_t [`FSCB_SLOTS-1:0] wb_entry,
    input  logic [`FSCB_NUM_REGS-1:0]             pending,
    input  logic                                  fdiv_req_ready,
    output logic                                  i0_waw_hazard,
    output logic                                  i1_waw_hazard,
    output logic                                  i0_struct_hazard,
    output logic                                  i1_struct_hazard
);

    import fscb_pkg::*;

    sb_entry_t [3*`FSCB_SLOTS-1:0] flight;
    logic [`FSCB_NUM_REGS-1:0]     fdiv_owed;
    logic                          same_rd;
    logic                          shared_fu;

    assign flight = {wb_entry, mm_entry, ex_entry};

    // divide results may land after a younger write, in the pipe or beyond it
    always_comb begin
        fdiv_owed = pending;
        for (int e = 0; e < 3*`FSCB_SLOTS; e++) begin
            if (flight[e].valid && flight[e].fu.fdiv) begin
                fdiv_owed[flight[e].rd] = 1'b1;
            end
        end
    end

    assign same_rd = i0_rd_wen && i1_rd_wen && (i0_rd == i1_rd);

    assign i0_waw_hazard = i0_rd_wen && fdiv_owed[i0_rd];
    assign i1_waw_hazard = (i1_rd_wen && fdiv_owed[i1_rd]) || same_rd;

    // one load port, one fmac and one divider per cycle
    assign shared_fu = (i0_fu.load && i1_fu.load) ||
                       (i0_fu.fmac && i1_fu.fmac) ||
                       (i0_fu.fdiv && i1_fu.fdiv);

    assign i0_struct_hazard = i0_fu.fdiv && !fdiv_req_ready;
    assign i1_struct_hazard = (i1_fu.fdiv && !fdiv_req_ready) || shared_fu;

endmodule

`default_nettype wire

/* design/fscb_top.sv */
// fp register scoreboard top joining stage tracker, divide pending map and hazard checks

`timescale 1ns/1ps
`default_nettype none

`include "fscb_settings.svh"

module fscb_top (
    input  logic                   core_clk,
    input  logic                   core_reset_n,
    // issue pair
    input  logic [`FSCB_REG_W-1:0] i0_rs1,
    input  logic [`FSCB_REG_W-1:0] i0_rs2,
    input  logic [`FSCB_REG_W-1:0] i0_rs3,
    input  logic [2:0]             i0_rs_ren,
    input  logic [`FSCB_REG_W-1:0] i0_rd,
    input  logic                   i0_rd_wen,
    input  fscb_pkg::fu_flags_t    i0_fu,
    input  logic [`FSCB_REG_W-1:0] i1_rs1,
    input  logic [`FSCB_REG_W-1:0] i1_rs2,
    input  logic [`FSCB_REG_W-1:0] i1_rs3,
    input  logic [2:0]             i1_rs_ren,
    input  logic [`FSCB_REG_W-1:0] i1_rd,
    input  logic                   i1_rd_wen,
    input  fscb_pkg::fu_flags_t    i1_fu,
    // instructions now in ex
    input  logic [`FSCB_REG_W-1:0] ex0_rd,
    input  logic                   ex0_rd_wen,
    input  fscb_pkg::fu_flags_t    ex0_fu,
    input  logic [`FSCB_REG_W-1:0] ex1_rd,
    input  logic                   ex1_rd_wen,
    input  fscb_pkg::fu_flags_t    ex1_fu,
    // pipeline control
    input  logic                   lx_stall,
    input  logic                   wb_kill,
    input  logic                   mm_i0_kill,
    input  logic                   mm_i1_kill,
    input  logic                   wb_i0_doable,
    input  logic                   wb_i1_doable,
    // divider
    input  logic                   fdiv_req_ready,
    input  logic                   fdiv_resp_return,
    input  logic [`FSCB_REG_W-1:0] fdiv_resp_tag,
    // issue flags
    output logic                   i0_raw_hazard,
    output logic                   i1_raw_hazard,
    output logic                   i0_waw_hazard,
    output logic                   i1_waw_hazard,
    output logic                   i0_struct_hazard,
    output logic                   i1_struct_hazard,
    output logic                   fdiv_kill
);

    import fscb_pkg::*;

    sb_entry_t [`FSCB_SLOTS-1:0] ex_entry;
    sb_entry_t [`FSCB_SLOTS-1:0] mm_entry;
    sb_entry_t [`FSCB_SLOTS-1:0] wb_entry;
    logic [`FSCB_NUM_REGS-1:0]   pending;

    assign ex_entry[0] = '{valid: ex0_rd_wen, rd: ex0_rd, fu: ex0_fu};
    assign ex_entry[1] = '{valid: ex1_rd_wen, rd: ex1_rd, fu: ex1_fu};

    fscb_stage_track fscb_stage_track_i (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .ex_entry     (ex_entry),
        .lx_stall     (lx_stall),
        .wb_kill      (wb_kill),
        .mm_i0_kill   (mm_i0_kill),
        .mm_i1_kill   (mm_i1_kill),
        .wb_i0_doable (wb_i0_doable),
        .wb_i1_doable (wb_i1_doable),
        .mm_entry     (mm_entry),
        .wb_entry     (wb_entry),
        .fdiv_kill    (fdiv_kill)
    );

    fscb_fdiv_pending fscb_fdiv_pending_i (
        .core_clk         (core_clk),
        .core_reset_n     (core_reset_n),
        .wb_entry         (wb_entry),
        .wb_i0_doable     (wb_i0_doable),
        .wb_i1_doable     (wb_i1_doable),
        .fdiv_resp_return (fdiv_resp_return),
        .fdiv_resp_tag    (fdiv_resp_tag),
        .pending          (pending)
    );

    fscb_raw_check fscb_raw_check_i (
        .i0_rs1           (i0_rs1),
        .i0_rs2           (i0_rs2),
        .i0_rs3           (i0_rs3),
        .i0_rs_ren        (i0_rs_ren),
        .i1_rs1           (i1_rs1),
        .i1_rs2           (i1_rs2),
        .i1_rs3           (i1_rs3),
        .i1_rs_ren        (i1_rs_ren),
        .i0_rd            (i0_rd),
        .i0_rd_wen        (i0_rd_wen),
        .ex_entry         (ex_entry),
        .mm_entry         (mm_entry),
        .wb_entry         (wb_entry),
        .pending          (pending),
        .fdiv_resp_return (fdiv_resp_return),
        .fdiv_resp_tag    (fdiv_resp_tag),
        .i0_raw_hazard    (i0_raw_hazard),
        .i1_raw_hazard    (i1_raw_hazard)
    );

    fscb_issue_check fscb_issue_check_i (
        .i0_rd            (i0_rd),
        .i0_rd_wen        (i0_rd_wen),
        .i0_fu            (i0_fu),
        .i1_rd            (i1_rd),
        .i1_rd_wen        (i1_rd_wen),
        .i1_fu            (i1_fu),
        .ex_entry         (ex_entry),
        .mm_entry         (mm_entry),
        .wb_entry         (wb_entry),
        .pending          (pending),
        .fdiv_req_ready   (fdiv_req_ready),
        .i0_waw_hazard    (i0_waw_hazard),
        .i1_waw_hazard    (i1_waw_hazard),
        .i0_struct_hazard (i0_struct_hazard),
        .i1_struct_hazard (i1_struct_hazard)
    );

endmodule

`default_nettype wire

/* tb/fscb_tb_table.svh */
// stimulus rows and hand-derived expected flags for the fp scoreboard testbench

`ifndef FSCB_TB_TABLE_SVH
`define FSCB_TB_TABLE_SVH

// expected flags {i0_raw, i1_raw, i0_waw, i1_waw, i0_struct, i1_struct, fdiv_kill}
add_row("reset_idle", 2, 7'b0000000);
set_ex(0, 3, FU_LD);
set_i0(3, 0, 0, 3'b001, 0, 0, FU_NONE);
add_row("raw_ex_load", 1, 7'b1000000);
set_i0(3, 0, 0, 3'b001, 0, 0, FU_NONE);
add_row("raw_mm_load_free", 1, 7'b0000000);
set_ex(1, 4, FU_MAC);
set_i1(0, 4, 0, 3'b010, 0, 0, FU_NONE);
add_row("raw_ex_fmac", 1, 7'b0100000);
set_i0(0, 0, 4, 3'b100, 0, 0, FU_NONE);
add_row("raw_mm_fmac", 1, 7'b1000000);
set_i1(4, 0, 0, 3'b001, 0, 0, FU_NONE);
add_row("raw_wb_fmac_free", 1, 7'b0000000);
set_ex(0, 6, FU_ALU);
set_i0(6, 0, 0, 3'b001, 0, 0, FU_NONE);
add_row("raw_ex_alu_free", 1, 7'b0000000);
set_i0(0, 0, 0, 3'b000, 7, 1, FU_ALU);
set_i1(7, 0, 0, 3'b001, 0, 0, FU_ALU);
add_row("raw_i1_on_i0_rd", 1, 7'b0100000);
set_ex(0, 9, FU_DIV);
set_i0(0, 9, 0, 3'b010, 0, 0, FU_NONE);
set_i1(0, 0, 0, 3'b000, 9, 1, FU_ALU);
add_row("fdiv_in_ex", 1, 7'b1001000);
set_i0(0, 0, 0, 3'b000, 9, 1, FU_ALU);
set_i1(0, 0, 9, 3'b100, 0, 0, FU_NONE);
add_row("fdiv_in_mm", 1, 7'b0110000);
set_i0(9, 0, 0, 3'b001, 0, 0, FU_NONE);
add_row("fdiv_in_wb", 1, 7'b1000000);
set_i0(9, 0, 0, 3'b001, 0, 0, FU_NONE);
set_i1(0, 0, 0, 3'b000, 9, 1, FU_ALU);
add_row("pending_raw_waw", 3, 7'b1001000);
set_i0(9, 0, 0, 3'b001, 9, 1, FU_ALU);
set_div(1, 1, 9);
add_row("resp_same_cycle", 1, 7'b0010000);
set_i0(9, 0, 0, 3'b001, 9, 1, FU_ALU);
add_row("after_resp", 1, 7'b0000000);
set_ex(1, 10, FU_MAC);
set_i0(10, 0, 0, 3'b001, 0, 0, FU_NONE);
add_row("stall_fmac_in_ex", 1, 7'b1000000);
set_ctl(1, 0, 0, 0, 1, 1);
set_i0(0, 10, 0, 3'b010, 0, 0, FU_NONE);
add_row("stall_hold", 3, 7'b1000000);
set_i1(10, 0, 0, 3'b001, 0, 0, FU_NONE);
add_row("stall_release", 1, 7'b0100000);
set_ex(0, 12, FU_DIV);
set_ctl(0, 1, 0, 0, 1, 1);
set_i0(12, 0, 0, 3'b001, 0, 0, FU_NONE);
add_row("wb_kill_ex_fdiv", 1, 7'b1000001);
set_i0(12, 0, 0, 3'b001, 12, 1, FU_ALU);
add_row("killed_ex_gone", 1, 7'b0000000);
set_ex(1, 13, FU_DIV);
add_row("fdiv_slot1_in_ex", 1, 7'b0000000);
set_ctl(0, 0, 1, 0, 1, 1);
set_i1(13, 0, 0, 3'b001, 0, 0, FU_NONE);
add_row("mm_i0_kill_fdiv", 1, 7'b0100001);
set_i1(13, 0, 0, 3'b001, 13, 1, FU_ALU);
add_row("killed_mm_gone", 1, 7'b0000000);
set_ex(1, 15, FU_DIV);
set_ctl(0, 0, 0, 1, 1, 1);
set_i0(15, 0, 0, 3'b001, 0, 0, FU_NONE);
add_row("mm_i1_kill_ex_fdiv", 1, 7'b1000001);
set_i0(15, 0, 0, 3'b001, 15, 1, FU_ALU);
add_row("killed_by_i1_gone", 1, 7'b0000000);
set_ex(0, 16, FU_DIV);
add_row("fdiv_slot0_to_mm", 1, 7'b0000000);
set_ctl(0, 1, 0, 0, 1, 1);
set_i0(16, 0, 0, 3'b001, 0, 0, FU_NONE);
add_row("wb_kill_mm_fdiv", 1, 7'b1000001);
set_i0(16, 0, 0, 3'b001, 16, 1, FU_ALU);
add_row("killed_mm0_gone", 1, 7'b0000000);
set_ex(0, 14, FU_DIV);
add_row("fdiv_slot0_in_ex", 1, 7'b0000000);
add_row("fdiv_slot0_to_wb", 1, 7'b0000000);
set_ctl(0, 0, 0, 0, 0, 1);
set_i0(14, 0, 0, 3'b001, 0, 0, FU_NONE);
add_row("wb_fdiv_not_doable", 1, 7'b1000001);
set_i0(14, 0, 0, 3'b001, 14, 1, FU_ALU);
add_row("not_doable_no_pending", 1, 7'b0000000);
set_i0(0, 0, 0, 3'b000, 0, 0, FU_DIV);
set_div(0, 0, 0);
add_row("fdiv_not_ready", 1, 7'b0000100);
set_i1(0, 0, 0, 3'b000, 0, 0, FU_DIV);
set_div(0, 0, 0);
add_row("fdiv_not_ready_i1", 1, 7'b0000010);
set_i0(0, 0, 0, 3'b000, 0, 0, FU_MAC);
set_i1(0, 0, 0, 3'b000, 0, 0, FU_MAC);
add_row("share_fmac", 1, 7'b0000010);
set_i0(0, 0, 0, 3'b000, 0, 0, FU_LD);
set_i1(0, 0, 0, 3'b000, 0, 0, FU_LD);
add_row("share_load", 1, 7'b0000010);
set_i0(0, 0, 0, 3'b000, 0, 0, FU_DIV);
set_i1(0, 0, 0, 3'b000, 0, 0, FU_DIV);
add_row("share_fdiv", 1, 7'b0000010);
set_i0(0, 0, 0, 3'b000, 20, 1, FU_ALU);
set_i1(0, 0, 0, 3'b000, 20, 1, FU_ALU);
add_row("same_rd_pair", 1, 7'b0001000);
add_row("final_idle", 1, 7'b0000000);

`endif

/* tb/fscb_tb.sv */
// testbench driving the fp scoreboard through a table of rows and checking all flags

`timescale 1ns/1ps
`default_nettype none

`include "fscb_settings.svh"

module fscb_tb;

    import fscb_pkg::*;

    localparam logic [3:0] FU_NONE = 4'b0000;
    localparam logic [3:0] FU_ALU  = 4'b1000;
    localparam logic [3:0] FU_LD   = 4'b0100;
    localparam logic [3:0] FU_MAC  = 4'b0010;
    localparam logic [3:0] FU_DIV  = 4'b0001;

    typedef struct {
        logic [4:0] i0_rs1, i0_rs2, i0_rs3, i0_rd, i1_rs1, i1_rs2, i1_rs3, i1_rd;
        logic [2:0] i0_ren, i1_ren;
        logic       i0_wen, i1_wen;
        logic [3:0] i0_fu, i1_fu;
        logic [4:0] ex_rd [2];
        logic       ex_wen [2];
        logic [3:0] ex_fu [2];
        logic [5:0] ctl;
        logic       ready, ret;
        logic [4:0] tag;
        int         cycles;
        logic [6:0] exp;
    } row_t;

    logic                   core_clk;
    logic                   core_reset_n;
    logic [`FSCB_REG_W-1:0] i0_rs1, i0_rs2, i0_rs3, i0_rd;
    logic [`FSCB_REG_W-1:0] i1_rs1, i1_rs2, i1_rs3, i1_rd;
    logic [2:0]             i0_rs_ren, i1_rs_ren;
    logic                   i0_rd_wen, i1_rd_wen;
    fu_flags_t              i0_fu, i1_fu, ex0_fu, ex1_fu;
    logic [`FSCB_REG_W-1:0] ex0_rd, ex1_rd, fdiv_resp_tag;
    logic                   ex0_rd_wen, ex1_rd_wen;
    logic                   lx_stall, wb_kill, mm_i0_kill, mm_i1_kill;
    logic                   wb_i0_doable, wb_i1_doable;
    logic                   fdiv_req_ready, fdiv_resp_return;
    logic [6:0]             flags;

    row_t  rows[$];
    string row_names[$];
    row_t  cur;
    int    cycle_count;
    int    cycle_limit;
    int    pass_count;
    int    fail_count;

    fscb_top fscb_top_i (
        .core_clk(core_clk), .core_reset_n(core_reset_n),
        .i0_rs1(i0_rs1), .i0_rs2(i0_rs2), .i0_rs3(i0_rs3), .i0_rs_ren(i0_rs_ren),
        .i0_rd(i0_rd), .i0_rd_wen(i0_rd_wen), .i0_fu(i0_fu),
        .i1_rs1(i1_rs1), .i1_rs2(i1_rs2), .i1_rs3(i1_rs3), .i1_rs_ren(i1_rs_ren),
        .i1_rd(i1_rd), .i1_rd_wen(i1_rd_wen), .i1_fu(i1_fu),
        .ex0_rd(ex0_rd), .ex0_rd_wen(ex0_rd_wen), .ex0_fu(ex0_fu),
        .ex1_rd(ex1_rd), .ex1_rd_wen(ex1_rd_wen), .ex1_fu(ex1_fu),
        .lx_stall(lx_stall), .wb_kill(wb_kill),
        .mm_i0_kill(mm_i0_kill), .mm_i1_kill(mm_i1_kill),
        .wb_i0_doable(wb_i0_doable), .wb_i1_doable(wb_i1_doable),
        .fdiv_req_ready(fdiv_req_ready), .fdiv_resp_return(fdiv_resp_return),
        .fdiv_resp_tag(fdiv_resp_tag),
        .i0_raw_hazard(flags[6]), .i1_raw_hazard(flags[5]),
        .i0_waw_hazard(flags[4]), .i1_waw_hazard(flags[3]),
        .i0_struct_hazard(flags[2]), .i1_struct_hazard(flags[1]),
        .fdiv_kill(flags[0])
    );

    // idle row: nothing read or written, both wb slots doable, divider ready
    function automatic row_t idle_row();
        row_t r;
        r = '{default: '0};
        r.ex_rd = '{0, 0};
        r.ex_wen = '{0, 0};
        r.ex_fu = '{0, 0};
        r.ctl = 6'b000011;
        r.ready = 1'b1;
        return r;
    endfunction

    task automatic set_i0(input logic [4:0] rs1, rs2, rs3, input logic [2:0] ren,
                          input logic [4:0] rd, input logic wen, input logic [3:0] fu);
        cur.i0_rs1 = rs1;
        cur.i0_rs2 = rs2;
        cur.i0_rs3 = rs3;
        cur.i0_ren = ren;
        cur.i0_rd = rd;
        cur.i0_wen = wen;
        cur.i0_fu = fu;
    endtask

    task automatic set_i1(input logic [4:0] rs1, rs2, rs3, input logic [2:0] ren,
                          input logic [4:0] rd, input logic wen, input logic [3:0] fu);
        cur.i1_rs1 = rs1;
        cur.i1_rs2 = rs2;
        cur.i1_rs3 = rs3;
        cur.i1_ren = ren;
        cur.i1_rd = rd;
        cur.i1_wen = wen;
        cur.i1_fu = fu;
    endtask

    task automatic set_ex(input int slot, input logic [4:0] rd, input logic [3:0] fu);
        cur.ex_rd[slot] = rd;
        cur.ex_wen[slot] = 1'b1;
        cur.ex_fu[slot] = fu;
    endtask

    // {stall, wb_kill, mm_i0_kill, mm_i1_kill, wb_i0_doable, wb_i1_doable}
    task automatic set_ctl(input logic st, wk, k0, k1, d0, d1);
        cur.ctl = {st, wk, k0, k1, d0, d1};
    endtask

    task automatic set_div(input logic ready, ret, input logic [4:0] tag);
        cur.ready = ready;
        cur.ret = ret;
        cur.tag = tag;
    endtask

    task automatic add_row(input string name, input int cycles, input logic [6:0] exp);
        row_names.push_back(name);
        cur.cycles = cycles;
        cur.exp = exp;
        rows.push_back(cur);
        cur = idle_row();
    endtask

    task automatic load_table();
        cur = idle_row();
        `include "fscb_tb_table.svh"
    endtask

    task automatic drive_row(input row_t r);
        {i0_rs1, i0_rs2, i0_rs3, i0_rs_ren} = {r.i0_rs1, r.i0_rs2, r.i0_rs3, r.i0_ren};
        {i0_rd, i0_rd_wen, i0_fu} = {r.i0_rd, r.i0_wen, r.i0_fu};
        {i1_rs1, i1_rs2, i1_rs3, i1_rs_ren} = {r.i1_rs1, r.i1_rs2, r.i1_rs3, r.i1_ren};
        {i1_rd, i1_rd_wen, i1_fu} = {r.i1_rd, r.i1_wen, r.i1_fu};
        {ex0_rd, ex0_rd_wen, ex0_fu} = {r.ex_rd[0], r.ex_wen[0], r.ex_fu[0]};
        {ex1_rd, ex1_rd_wen, ex1_fu} = {r.ex_rd[1], r.ex_wen[1], r.ex_fu[1]};
        {lx_stall, wb_kill, mm_i0_kill, mm_i1_kill, wb_i0_doable, wb_i1_doable} = r.ctl;
        {fdiv_req_ready, fdiv_resp_return, fdiv_resp_tag} = {r.ready, r.ret, r.tag};
    endtask

    initial begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    always @(posedge core_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        cycle_count = 0;
        cycle_limit = 0;
        pass_count = 0;
        fail_count = 0;
        core_reset_n = 1'b0;
        load_table();
        drive_row(idle_row());
        foreach (rows[n]) begin
            cycle_limit += rows[n].cycles;
        end
        cycle_limit += 20;
        repeat (5) @(posedge core_clk);
        @(negedge core_clk);
        core_reset_n = 1'b1;
        foreach (rows[n]) begin
            @(negedge core_clk);
            drive_row(rows[n]);
            repeat (rows[n].cycles - 1) @(negedge core_clk);
            // sample mid low phase, well before the next rising edge
            #5;
            if (flags !== rows[n].exp) begin
                $display("[FAIL] %s expected %b actual %b", row_names[n], rows[n].exp, flags);
                fail_count++;
            end else begin
                $display("[PASS] %s flags %b", row_names[n], flags);
                pass_count++;
            end
        end
        $display("rows %0d passed %0d failed %0d", rows.size(), pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+common
+incdir+tb
common/fscb_pkg.sv
stage_track/fscb_stage_track.sv
fdiv_pending/fscb_fdiv_pending.sv
hazard/fscb_raw_check.sv
hazard/fscb_issue_check.sv
design/fscb_top.sv
tb/fscb_tb.sv

/* Makefile */
# Verilator build for the fp scoreboard testbench

VERILATOR ?= verilator
TOP       ?= fscb_tb
RTL_TOP   ?= fscb_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^sim passed$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
